// File: src.f
+incdir+verification
hdl/loader_pkg.sv
hdl/ines_header_decode.sv
hdl/rom_load_execute.sv
hdl/load_result.sv
hdl/game_loader.sv
verification/game_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cartridge loader testbench with Verilator, run it and check the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module game_loader_tb -o sim_game_loader &&
out=$(./obj_dir/sim_game_loader) &&
echo "$out" &&
echo "$out" | grep -qx "No errors" && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: verification/game_loader_tb_util.svh
/*
 * Testbench helpers
 * Byte source, image streaming and the mapper flag model built from the raw header
 */

	// Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit taken
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	task automatic set_header(input logic [7:0] prg, input logic [7:0] chr,
	                          input logic [7:0] f6, input logic [7:0] f7);
		foreach (hdr[i])
			hdr[i] = 8'h00;
		{hdr[0], hdr[1], hdr[2], hdr[3]} = loader_pkg::NES_MAGIC;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = f6;
		hdr[7] = f7;
	endtask

	// One strobe per byte in a memory slot cycle
	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		while (phase != 2'd3)
			@(posedge clk);
		in_byte   <= b;
		in_strobe <= 1'b1;
		@(posedge clk);
		in_strobe <= 1'b0;
	endtask

	// Body section with each byte logged as the write it has to become
	task automatic send_block(input logic [7:0] pages, input int shift,
	                          input logic [loader_pkg::ADDR_W-1:0] base);
		logic [7:0] b;
		for (int i = 0; i < (int'(pages) << shift); i++) begin
			b = rand_byte();
			exp_w[sent] = {base + loader_pkg::ADDR_W'(i), b};
			sent        = sent + 1;
			send_byte(b);
		end
	endtask

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("MISMATCH at %0t: %s", $time, msg);
		end
	endtask

	// Smallest n with pages <= 2^n or 7 past 64 pages
	function automatic logic [2:0] page_size_code(input logic [7:0] pages);
		for (int n = 0; n < 7; n++)
			if (int'(pages) <= (1 << n))
				return 3'(n);
		return 3'd7;
	endfunction

	function automatic loader_pkg::mapper_flags_t model_flags(input logic inv);
		loader_pkg::mapper_flags_t f;
		logic nes20;
		logic dirty;
		nes20 = (hdr[7][3:2] == 2'b10);
		dirty = !nes20 && (hdr[9][7:1] != 7'd0 ||
		        {hdr[10], hdr[11], hdr[12], hdr[13], hdr[14], hdr[15]} != 48'd0);
		f             = '0;
		f.has_saves   = hdr[6][1];
		f.submapper   = nes20 ? hdr[8] : 8'h00;
		f.four_screen = hdr[6][3];
		f.chr_ram     = (hdr[5] == 8'd0);
		f.mirroring   = hdr[6][0] ^ inv;
		f.chr_size    = page_size_code(hdr[5]);
		f.prg_size    = page_size_code(hdr[4]);
		f.mapper      = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]}; // Old rippers garble byte 7
		return f;
	endfunction

// File: verification/game_loader_tb.sv
/*
 * Cartridge loader testbench
 * Streams iNES images into the loader and checks writes, status and flags
 */
`timescale 1ns/1ps

module game_loader_tb;

	// PRG and CHR bytes of the five images plus junk after the bad headers
	localparam int BODY_BYTES = 24576 + 8 + 8 + 32768 + 16384;
	localparam int MAX_CYCLES = 13 * 4 * (BODY_BYTES + 5 * 116) / 10;

	logic                      clk = 1'b0;
	logic                      reset_nes;
	logic [7:0]                in_byte;
	logic                      in_strobe;
	logic                      downloading;
	logic                      invert_mirroring;
	logic                      mem_slot = 1'b0;
	loader_pkg::mem_write_t    mem_req;
	logic                      mem_we;
	logic                      busy;
	logic                      done;
	logic                      error;
	loader_pkg::mapper_flags_t mapper_flags;

	logic [7:0]             hdr [loader_pkg::HEADER_BYTES];
	logic [16:0]            lfsr = 17'd66981;
	logic [1:0]             phase = 2'd0;
	loader_pkg::mem_write_t exp_w [BODY_BYTES];
	int sent = 0; // Writes queued by the stimulus
	int seen = 0; // Writes seen on the memory side
	int cycles = 0;
	int tests = 0;
	int checks = 0;
	int errors = 0;
	int mon_errors = 0;
	int prop_errors = 0;

	`include "game_loader_tb_util.svh"

	game_loader game_loader_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		phase    <= phase + 2'd1;
		mem_slot <= (phase == 2'd3); // Every 4th cycle
	end

	// Memory side checks each write against the byte that was sent
	always @(posedge clk) begin
		if (mem_we) begin
			assert (mem_slot && seen < sent) else begin
				mon_errors <= mon_errors + 1;
				$display("Memory write to %06h outside a slot or with no byte sent", mem_req.addr);
			end
			assert (seen >= sent || mem_req == exp_w[seen]) else begin
				mon_errors <= mon_errors + 1;
				$display("MISMATCH at %0t: write %0d is %06h/%02h, expected %06h/%02h", $time,
				         seen, mem_req.addr, mem_req.data, exp_w[seen].addr, exp_w[seen].data);
			end
			seen <= seen + 1;
		end
	end

	assert property (@(posedge clk) $past(reset_nes) |-> !(busy || done || error || mem_we))
	else begin
		prop_errors = prop_errors + 1;
		$display("MISMATCH at %0t: status or write strobe high after reset", $time);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles with tests unfinished", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// Reset, stream one image, then check status and flags
	task automatic load_image(input string name, input logic inv);
		int                        err_start;
		logic                      valid;
		loader_pkg::mapper_flags_t want;
		err_start = errors + mon_errors + prop_errors;
		valid = ({hdr[0], hdr[1], hdr[2], hdr[3]} == loader_pkg::NES_MAGIC) && !hdr[6][2];
		reset_nes <= 1'b1;
		repeat (8) @(posedge clk);
		reset_nes        <= 1'b0;
		invert_mirroring <= inv;
		downloading      <= 1'b1;
		for (int i = 0; i < loader_pkg::HEADER_BYTES; i++) begin
			check(!busy, "busy high before the 16th header byte");
			send_byte(hdr[i]);
		end
		@(posedge clk);
		check(busy, "busy low after the 16th header byte");
		if (valid) begin
			send_block(hdr[4], loader_pkg::PRG_PAGE_SHIFT, '0);
			send_block(hdr[5], loader_pkg::CHR_PAGE_SHIFT, loader_pkg::CHR_BASE);
		end else begin
			repeat (8) send_byte(rand_byte()); // Must not reach memory
		end
		while (!done)
			@(posedge clk);
		while (seen < sent)
			@(posedge clk);
		repeat (2) @(posedge clk);
		check(done && !busy && error == !valid, "done, busy or error wrong after the load");
		check(mapper_flags == '0, "mapper flags not zero while downloading");
		downloading <= 1'b0;
		repeat (2) @(posedge clk);
		want = valid ? model_flags(inv) : 32'd0;
		check(mapper_flags == want, $sformatf("mapper flags %08h, expected %08h",
		      mapper_flags, want));
		tests++;
		$display("Test %0d %s: %s", tests, name,
		         (errors + mon_errors + prop_errors == err_start) ? "PASS" : "FAIL");
	endtask

	initial begin
		int total;
		reset_nes        <= 1'b1;
		in_byte          <= 8'h00;
		in_strobe        <= 1'b0;
		downloading      <= 1'b0;
		invert_mirroring <= 1'b0;
		set_header(8'd1, 8'd1, 8'h13, 8'h40); // Mapper 0x41, saves, vertical
		load_image("prg_chr_load", 1'b0);
		set_header(8'd1, 8'd1, 8'h13, 8'h40);
		hdr[2] = 8'h54;
		load_image("bad_magic", 1'b0);
		set_header(8'd1, 8'd1, 8'h04, 8'h00);
		load_image("trainer", 1'b0);
		set_header(8'd2, 8'd0, 8'h2A, 8'h50); // CHR RAM and four screen
		hdr[8]  = 8'h09;
		hdr[12] = 8'h44;
		load_image("dirty_chr_ram", 1'b0);
		set_header(8'd1, 8'd0, 8'h31, 8'h78); // iNES 2.0 with mapper 0x73
		hdr[8]  = 8'h25;
		hdr[12] = 8'h11;
		load_image("nes20_invert", 1'b1);
		total = errors + mon_errors + prop_errors;
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, total);
		if (total == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: hdl/game_loader.sv
/*
 * Cartridge loader top
 * iNES image stream in, staged memory writes and mapper flags out
 */
`timescale 1ns/1ps

module game_loader (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic [7:0]                in_byte,
	input  logic                      in_strobe,
	input  logic                      downloading,
	input  logic                      invert_mirroring,
	input  logic                      mem_slot,
	output loader_pkg::mem_write_t    mem_req,
	output logic                      mem_we,
	output logic                      busy,
	output logic                      done,
	output logic                      error,
	output loader_pkg::mapper_flags_t mapper_flags
);

	loader_pkg::header_t    header;
	logic                   header_ready;
	logic                   header_capture;
	loader_pkg::mem_write_t wr;
	logic                   wr_valid;
	logic                   load_done;

	ines_header_decode decode_i (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.in_byte        (in_byte),
		.in_strobe      (in_strobe),
		.header_capture (header_capture),
		.header         (header),
		.header_ready   (header_ready)
	);

	rom_load_execute execute_i (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.in_byte        (in_byte),
		.in_strobe      (in_strobe),
		.header         (header),
		.header_ready   (header_ready),
		.header_capture (header_capture),
		.wr             (wr),
		.wr_valid       (wr_valid),
		.load_done      (load_done),
		.busy           (busy),
		.done           (done),
		.error          (error)
	);

	load_result result_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.wr               (wr),
		.wr_valid         (wr_valid),
		.mem_slot         (mem_slot),
		.load_done        (load_done),
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.downloading      (downloading),
		.mem_req          (mem_req),
		.mem_we           (mem_we),
		.mapper_flags     (mapper_flags)
	);

endmodule

// File: hdl/load_result.sv
/*
 * Load result stage
 * Holds each loader write until the next memory slot and latches the
 * mapper flag word when the load completes
 */
`timescale 1ns/1ps

module load_result (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  loader_pkg::mem_write_t    wr,
	input  logic                      wr_valid,
	input  logic                      mem_slot,
	input  logic                      load_done,
	input  loader_pkg::header_t       header,
	input  logic                      invert_mirroring,
	input  logic                      downloading,
	output loader_pkg::mem_write_t    mem_req,
	output logic                      mem_we,
	output loader_pkg::mapper_flags_t mapper_flags
);

	logic                      pending;
	loader_pkg::mapper_flags_t flags_q;
	loader_pkg::mapper_flags_t flags_next;

	// Smallest n with pages <= 2^n, 7 for anything past 64 pages
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--)
			if (pages <= (8'd1 << n))
				code = 3'(n);
		return code;
	endfunction

	// A new write in the slot cycle replaces the one just released
	always_ff @(posedge clk) begin
		if (reset_nes)
			pending <= 1'b0;
		else if (wr_valid)
			pending <= 1'b1;
		else if (mem_slot)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_valid)
			mem_req <= wr;
	end

	assign mem_we = pending && mem_slot;

	always_comb begin
		flags_next             = '0;
		flags_next.has_saves   = header.has_saves;
		flags_next.submapper   = header.submapper;
		flags_next.four_screen = header.four_screen;
		flags_next.chr_ram     = (header.chr_pages == 8'd0);
		flags_next.mirroring   = header.mirroring ^ invert_mirroring;
		flags_next.chr_size    = size_code(header.chr_pages);
		flags_next.prg_size    = size_code(header.prg_pages);
		flags_next.mapper      = header.mapper;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			flags_q <= '0;
		else if (load_done)
			flags_q <= flags_next;
	end

	assign mapper_flags = downloading ? '0 : flags_q; // Core sees no cart mid-download

endmodule

// File: hdl/rom_load_execute.sv
/*
 * ROM load state machine
 * Walks the image body through PRG then CHR, generating the write address
 * and strobe per byte, and reports busy, done and error
 */
`timescale 1ns/1ps

module rom_load_execute (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic [7:0]             in_byte,
	input  logic                   in_strobe,
	input  loader_pkg::header_t    header,
	input  logic                   header_ready,
	output logic                   header_capture,
	output loader_pkg::mem_write_t wr,
	output logic                   wr_valid,
	output logic                   load_done,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);

	loader_pkg::load_state_t       state;
	logic [loader_pkg::ADDR_W-1:0] addr;
	logic [loader_pkg::ADDR_W-1:0] bytes_left; // Header byte count while in HEADER
	logic [loader_pkg::ADDR_W-1:0] prg_bytes;
	logic [loader_pkg::ADDR_W-1:0] chr_bytes;
	logic                          in_body;
	logic                          header_ok;

	assign prg_bytes = {{(loader_pkg::ADDR_W - 8){1'b0}}, header.prg_pages}
	                   << loader_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = {{(loader_pkg::ADDR_W - 8){1'b0}}, header.chr_pages}
	                   << loader_pkg::CHR_PAGE_SHIFT;

	// Trainers are not supported
	assign header_ok = header.magic_ok && !header.trainer;

	assign header_capture = (state == loader_pkg::HEADER);
	assign in_body = (state == loader_pkg::PRG) || (state == loader_pkg::CHR);

	assign wr_valid = in_body && in_strobe && (bytes_left != '0);
	assign wr.addr  = addr;
	assign wr.data  = in_byte;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= loader_pkg::HEADER;
			addr       <= '0;
			bytes_left <= '0;
			load_done  <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			load_done <= 1'b0;
			case (state)
				loader_pkg::HEADER: begin
					if (header_ready) begin
						if (header_ok) begin
							state      <= loader_pkg::PRG;
							addr       <= '0;
							bytes_left <= prg_bytes;
						end else begin
							state <= loader_pkg::ERROR;
							error <= 1'b1;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end else if (in_strobe) begin
						bytes_left <= bytes_left + 1'b1;
						if (bytes_left == loader_pkg::ADDR_W'(loader_pkg::HEADER_BYTES - 1))
							busy <= 1'b1; // Last header byte
					end
				end
				loader_pkg::PRG, loader_pkg::CHR: begin
					if (bytes_left != '0) begin
						if (in_strobe) begin
							addr       <= addr + 1'b1;
							bytes_left <= bytes_left - 1'b1;
						end
					end else if (state == loader_pkg::PRG) begin
						state      <= loader_pkg::CHR;
						addr       <= loader_pkg::CHR_BASE;
						bytes_left <= chr_bytes; // Zero for CHR RAM carts
					end else begin
						state     <= loader_pkg::DONE;
						load_done <= 1'b1;
						done      <= 1'b1;
						busy      <= 1'b0;
					end
				end
				loader_pkg::DONE, loader_pkg::ERROR: begin
					// Parked until the next reset
				end
				default: state <= loader_pkg::ERROR;
			endcase
		end
	end

endmodule

// File: hdl/ines_header_decode.sv
/*
 * iNES header decode
 * Captures the 16 header bytes of the incoming image and splits them into
 * the fields needed by the loader, telling dirty 1.0 headers from 2.0 ones
 */
`timescale 1ns/1ps

module ines_header_decode (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic [7:0]            in_byte,
	input  logic                  in_strobe,
	input  logic                  header_capture,
	output loader_pkg::header_t   header,
	output logic                  header_ready
);

	localparam int CTR_W = $clog2(loader_pkg::HEADER_BYTES);

	logic [7:0]       hdr_bytes [loader_pkg::HEADER_BYTES];
	logic [CTR_W-1:0] ctr;
	logic             take_byte;
	logic             last_byte;
	logic             is_nes20;
	logic             is_dirty;
	logic             tail_nonzero;

	// Hold off once the header is complete until the loader moves on
	assign take_byte = header_capture && in_strobe && !header_ready;
	assign last_byte = (ctr == CTR_W'(loader_pkg::HEADER_BYTES - 1));

	always_ff @(posedge clk) begin
		if (take_byte)
			hdr_bytes[ctr] <= in_byte;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			ctr <= '0;
			header_ready <= 1'b0;
		end else begin
			header_ready <= take_byte && last_byte;
			if (take_byte)
				ctr <= ctr + 1'b1; // Wraps to 0 after byte 15
		end
	end

	// iNES 2.0 signature in byte 7
	assign is_nes20 = (hdr_bytes[7][3:2] == 2'b10);

	always_comb begin
		tail_nonzero = (hdr_bytes[9][7:1] != 7'd0);
		for (int i = 10; i < loader_pkg::HEADER_BYTES; i++)
			tail_nonzero = tail_nonzero || (hdr_bytes[i] != 8'd0);
	end

	// Junk in the reserved bytes means an old ripper wrote over them
	assign is_dirty = !is_nes20 && tail_nonzero;

	always_comb begin
		header.magic_ok    = ({hdr_bytes[0], hdr_bytes[1], hdr_bytes[2], hdr_bytes[3]}
		                      == loader_pkg::NES_MAGIC);
		header.trainer     = hdr_bytes[6][2];
		header.prg_pages   = hdr_bytes[4];
		header.chr_pages   = hdr_bytes[5];
		header.mapper      = {is_dirty ? 4'h0 : hdr_bytes[7][7:4], hdr_bytes[6][7:4]};
		header.submapper   = is_nes20 ? hdr_bytes[8] : 8'h00;
		header.mirroring   = hdr_bytes[6][0]; // Vertical when set
		header.four_screen = hdr_bytes[6][3];
		header.has_saves   = hdr_bytes[6][1]; // Battery backed RAM
	end

endmodule

// File: hdl/loader_pkg.sv
/*
 * Cartridge loader package
 * Loader constants, decoded iNES header, mapper flag word, memory write
 * request and the load state encoding
 */
package loader_pkg;

	localparam int HEADER_BYTES   = 16;
	localparam int ADDR_W         = 22;
	localparam int PRG_PAGE_SHIFT = 14; // 16 KB PRG pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KB CHR pages

	// CHR lives in the upper half of the loader address space
	localparam logic [ADDR_W-1:0] CHR_BASE = {1'b1, {(ADDR_W-1){1'b0}}};

	// "NES" followed by MS-DOS EOF, byte 0 in the top bits
	localparam logic [31:0] NES_MAGIC = 32'h4E45_531A;

	typedef struct packed {
		logic       magic_ok;
		logic       trainer;
		logic [7:0] prg_pages;
		logic [7:0] chr_pages;
		logic [7:0] mapper;
		logic [7:0] submapper;
		logic       mirroring;
		logic       four_screen;
		logic       has_saves;
	} header_t;

	// Flag word handed to the console core
	typedef struct packed {
		logic [5:0] pad;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_write_t;

	typedef enum logic [2:0] {
		HEADER,
		PRG,
		CHR,
		DONE,
		ERROR
	} load_state_t;

endpackage
